//--- Bender.yml
package:
  name: dcache

sources:
  - include_dirs:
      - source
    files:
      - source/dcache_pkg.sv
      - source/mem_bus_pkg.sv
      - source/dcache_lookup.sv
      - source/dcache_miss_queue.sv
      - source/dcache_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - verif/dcache_props.sv
      - verif/dcache_tb.sv

//--- files.f
+incdir+source
source/dcache_pkg.sv
source/mem_bus_pkg.sv
source/dcache_lookup.sv
source/dcache_miss_queue.sv
source/dcache_top.sv
verif/dcache_props.sv
verif/dcache_tb.sv

//--- source/dcache_lookup.sv
/*
 * lookup stage of the data cache
 *   cache lines with true LRU ranks
 *   four-phase req/ack FSM toward the lsq
 *   hit extraction, store merge and fill install
 */

`timescale 1ns/1ps

`include "dcache_params.svh"

module dcache_lookup
    import dcache_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  logic       lsq_req,
    input  lsq_req_t   lsq_req_data,
    input  fill_t      fill,
    input  logic       queue_ready,
    output logic       lsq_ack,
    output lsq_rsp_t   lsq_rsp,
    output logic       miss_push,
    output miss_rec_t  miss_rec
);

    localparam int IDX_BITS = $clog2(`DC_LINES);
    localparam logic [DC_RANK_BITS-1:0] TOP_RANK = DC_RANK_BITS'(`DC_LINES - 1);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_RESPOND,
        ST_WAIT_FILL,
        ST_WAIT_PUSH,
        ST_RELEASE
    } lookup_state_e;

    lookup_state_e                  state;
    cache_line_t                    lines [`DC_LINES];
    lsq_req_t                       req_q;

    logic [DC_LINE_ADDR_BITS-1:0]   req_line;
    logic                           hit;
    logic [IDX_BITS-1:0]            hit_idx;
    logic [IDX_BITS-1:0]            victim_idx;
    logic [7:0]                     store_be;
    logic [63:0]                    store_bits;
    logic [63:0]                    lane_data;
    logic [63:0]                    merged;

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////

    function automatic logic [31:0] extract(input logic [63:0] data, input logic [2:0] off,
                                            input access_size_e size);
        logic [63:0] shifted;
        shifted = data >> {off, 3'b000};
        case (size)
            SIZE_BYTE: extract = {24'b0, shifted[7:0]};
            SIZE_HALF: extract = {16'b0, shifted[15:0]};
            default:   extract = shifted[31:0];
        endcase
    endfunction

    function automatic logic [7:0] byte_mask(input logic [2:0] off, input access_size_e size);
        logic [7:0] base;
        case (size)
            SIZE_BYTE: base = 8'b0000_0001;
            SIZE_HALF: base = 8'b0000_0011;
            default:   base = 8'b0000_1111;
        endcase
        byte_mask = base << off;
    endfunction

    function automatic logic [63:0] expand_mask(input logic [7:0] be);
        for (int b = 0; b < 8; b++) begin
            expand_mask[b*8 +: 8] = {8{be[b]}};
        end
    endfunction

    // touched line goes to the top, lines above its old rank slide down
    function automatic logic [DC_RANK_BITS-1:0] next_rank(input logic [DC_RANK_BITS-1:0] rank,
                                                          input logic [DC_RANK_BITS-1:0] touched,
                                                          input logic is_touched);
        if (is_touched) begin
            next_rank = TOP_RANK;
        end else if (rank > touched) begin
            next_rank = rank - 1'b1;
        end else begin
            next_rank = rank;
        end
    endfunction

    //////////////////////////////////////////////////
    // tag search and victim select
    //////////////////////////////////////////////////

    assign req_line = lsq_req_data.addr[`DC_ADDR_BITS-1:3];

    always_comb begin
        hit     = 1'b0;
        hit_idx = '0;
        for (int i = 0; i < `DC_LINES; i++) begin
            if (lines[i].valid && lines[i].line_addr == req_line) begin
                hit     = 1'b1;
                hit_idx = IDX_BITS'(i);
            end
        end
    end

    // invalid lines first, lowest index wins
    always_comb begin
        logic found_invalid;
        found_invalid = 1'b0;
        victim_idx    = '0;
        for (int i = 0; i < `DC_LINES; i++) begin
            if (!found_invalid && !lines[i].valid) begin
                found_invalid = 1'b1;
                victim_idx    = IDX_BITS'(i);
            end
        end
        if (!found_invalid) begin
            for (int i = 0; i < `DC_LINES; i++) begin
                if (lines[i].rank == '0) begin
                    victim_idx = IDX_BITS'(i);
                end
            end
        end
    end

    // store bytes placed in their lanes
    always_comb begin
        store_be   = byte_mask(lsq_req_data.addr[2:0], lsq_req_data.size);
        store_bits = expand_mask(store_be);
        lane_data  = 64'(lsq_req_data.value) << {lsq_req_data.addr[2:0], 3'b000};
        merged     = (lines[hit_idx].data & ~store_bits) | (lane_data & store_bits);
    end

    //////////////////////////////////////////////////
    // request FSM
    //////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            state     <= ST_IDLE;
            lsq_ack   <= 1'b0;
            miss_push <= 1'b0;
            for (int i = 0; i < `DC_LINES; i++) begin
                lines[i].valid <= 1'b0;
                lines[i].rank  <= DC_RANK_BITS'(i);
            end
        end else begin
            case (state)
                ST_IDLE: begin
                    if (lsq_req && !lsq_ack) begin
                        req_q <= lsq_req_data;
                        if (hit) begin
                            for (int i = 0; i < `DC_LINES; i++) begin
                                lines[i].rank <= next_rank(lines[i].rank, lines[hit_idx].rank,
                                                           IDX_BITS'(i) == hit_idx);
                            end
                        end
                        if (lsq_req_data.op == OP_LOAD) begin
                            if (hit) begin
                                lsq_rsp.value <= extract(lines[hit_idx].data,
                                                         lsq_req_data.addr[2:0],
                                                         lsq_req_data.size);
                                state <= ST_RESPOND;
                            end else begin
                                miss_rec  <= '{kind: MISS_FILL, line_addr: req_line,
                                               data: '0, be: '0};
                                miss_push <= 1'b1;
                                state     <= ST_WAIT_PUSH;
                            end
                        end else begin
                            // write-through, no allocate on a miss
                            miss_push <= 1'b1;
                            state     <= ST_WAIT_PUSH;
                            if (hit) begin
                                lines[hit_idx].data <= merged;
                                miss_rec <= '{kind: MISS_WRITE, line_addr: req_line,
                                              data: merged, be: 8'hff};
                            end else begin
                                miss_rec <= '{kind: MISS_WRITE, line_addr: req_line,
                                              data: lane_data & store_bits, be: store_be};
                            end
                        end
                    end
                end
                ST_WAIT_PUSH: begin
                    if (queue_ready) begin
                        miss_push <= 1'b0;
                        if (req_q.op == OP_LOAD) begin
                            state <= ST_WAIT_FILL;
                        end else begin
                            lsq_ack <= 1'b1;
                            state   <= ST_RELEASE;
                        end
                    end
                end
                ST_WAIT_FILL: begin
                    if (fill.valid) begin
                        for (int i = 0; i < `DC_LINES; i++) begin
                            lines[i].rank <= next_rank(lines[i].rank, lines[victim_idx].rank,
                                                       IDX_BITS'(i) == victim_idx);
                        end
                        lines[victim_idx].valid     <= 1'b1;
                        lines[victim_idx].line_addr <= fill.line_addr;
                        lines[victim_idx].data      <= fill.data;
                        lsq_rsp.value <= extract(fill.data, req_q.addr[2:0], req_q.size);
                        state         <= ST_RESPOND;
                    end
                end
                ST_RESPOND: begin
                    lsq_ack <= 1'b1;
                    state   <= ST_RELEASE;
                end
                ST_RELEASE: begin
                    if (!lsq_req) begin
                        lsq_ack <= 1'b0;
                        state   <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

//--- source/dcache_miss_queue.sv
/*
 * miss queue stage of the data cache
 *   in-order queue of fills and write-throughs
 *   tagged offer/accept toward memory
 *   fill return matching and drain flag
 */

`timescale 1ns/1ps

`include "dcache_params.svh"

module dcache_miss_queue
    import dcache_pkg::*;
    import mem_bus_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  logic       miss_push,
    input  miss_rec_t  miss_rec,
    input  mem_rsp_t   mem_rsp,
    output logic       queue_ready,
    output fill_t      fill,
    output mem_req_t   mem_req,
    output logic       drained
);

    localparam int PTR_BITS = $clog2(`DC_MISS_DEPTH);

    typedef struct packed {
        logic                      valid;
        logic                      issued;
        logic [`MEM_TAG_BITS-1:0]  tag;
        miss_rec_t                 rec;
    } q_entry_t;

    q_entry_t             entries [`DC_MISS_DEPTH];
    logic [PTR_BITS-1:0]  head_ptr;
    logic [PTR_BITS-1:0]  tail_ptr;
    q_entry_t             head;
    logic                 offer;
    logic                 accepted;
    logic                 fill_done;

    // lookup blocks on a load miss, so only the head can be in flight
    assign head        = entries[head_ptr];
    assign queue_ready = !entries[tail_ptr].valid;

    assign offer     = head.valid && !head.issued;
    assign accepted  = offer && (mem_rsp.accept_tag != '0);
    assign fill_done = head.valid && head.issued && (head.rec.kind == MISS_FILL) &&
                       (mem_rsp.data_tag != '0) && (mem_rsp.data_tag == head.tag);

    //////////////////////////////////////////////////
    // memory offer
    //////////////////////////////////////////////////

    always_comb begin
        mem_req = '{cmd: BUS_NONE, addr: '0, data: '0, be: '0};
        if (offer) begin
            mem_req.cmd  = (head.rec.kind == MISS_FILL) ? BUS_LOAD : BUS_STORE;
            mem_req.addr = {head.rec.line_addr, 3'b000};
            mem_req.data = head.rec.data;
            mem_req.be   = head.rec.be;
        end
    end

    // low while any write-through is still queued
    always_comb begin
        drained = 1'b1;
        for (int i = 0; i < `DC_MISS_DEPTH; i++) begin
            if (entries[i].valid && entries[i].rec.kind == MISS_WRITE) begin
                drained = 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////
    // queue state
    //////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            head_ptr   <= '0;
            tail_ptr   <= '0;
            fill.valid <= 1'b0;
            for (int i = 0; i < `DC_MISS_DEPTH; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else begin
            fill.valid <= 1'b0;

            if (miss_push && queue_ready) begin
                entries[tail_ptr].valid  <= 1'b1;
                entries[tail_ptr].issued <= 1'b0;
                entries[tail_ptr].rec    <= miss_rec;
                tail_ptr                 <= tail_ptr + 1'b1;
            end

            // writes retire on accept, fills wait for their data
            if (accepted) begin
                if (head.rec.kind == MISS_WRITE) begin
                    entries[head_ptr].valid <= 1'b0;
                    head_ptr                <= head_ptr + 1'b1;
                end else begin
                    entries[head_ptr].issued <= 1'b1;
                    entries[head_ptr].tag    <= mem_rsp.accept_tag;
                end
            end

            if (fill_done) begin
                entries[head_ptr].valid <= 1'b0;
                head_ptr                <= head_ptr + 1'b1;
                fill.valid              <= 1'b1;
                fill.line_addr          <= head.rec.line_addr;
                fill.data               <= mem_rsp.data;
            end
        end
    end

endmodule

//--- source/dcache_params.svh
/*
 * size macros shared by the data cache
 *   cache line count and miss queue depth
 *   byte address width
 *   memory transaction tag width (tag zero means refused)
 */

`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

// fully associative, 64-bit lines
`define DC_LINES 8

// outstanding fills plus write-throughs
`define DC_MISS_DEPTH 4

// byte address, 64 KB space
`define DC_ADDR_BITS 16

// memory side tag, nonzero when accepted
`define MEM_TAG_BITS 4

`endif

//--- source/dcache_pkg.sv
/*
 * cache-side types
 *   access size and load/store opcode enums
 *   lsq request and response bundles
 *   cache line, miss record and fill record
 */

`include "dcache_params.svh"

package dcache_pkg;

    // address bits above the byte offset in a line
    localparam int DC_LINE_ADDR_BITS = `DC_ADDR_BITS - 3;
    localparam int DC_RANK_BITS      = $clog2(`DC_LINES);

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } access_size_e;

    typedef enum logic {
        OP_LOAD  = 1'b0,
        OP_STORE = 1'b1
    } lsq_op_e;

    typedef enum logic {
        MISS_FILL  = 1'b0,
        MISS_WRITE = 1'b1
    } miss_kind_e;

    typedef struct packed {
        lsq_op_e                   op;
        access_size_e              size;
        logic [`DC_ADDR_BITS-1:0]  addr;
        logic [31:0]               value;
    } lsq_req_t;

    typedef struct packed {
        logic [31:0] value;
    } lsq_rsp_t;

    // highest rank is most recently used
    typedef struct packed {
        logic                          valid;
        logic [DC_LINE_ADDR_BITS-1:0]  line_addr;
        logic [63:0]                   data;
        logic [DC_RANK_BITS-1:0]       rank;
    } cache_line_t;

    typedef struct packed {
        miss_kind_e                    kind;
        logic [DC_LINE_ADDR_BITS-1:0]  line_addr;
        logic [63:0]                   data;
        logic [7:0]                    be;
    } miss_rec_t;

    typedef struct packed {
        logic                          valid;
        logic [DC_LINE_ADDR_BITS-1:0]  line_addr;
        logic [63:0]                   data;
    } fill_t;

endpackage

//--- source/dcache_top.sv
/*
 * data cache top level
 *   lookup stage and miss queue stage
 *   lsq req/ack port and tagged memory port
 */

`timescale 1ns/1ps

module dcache_top
    import dcache_pkg::*;
    import mem_bus_pkg::*;
(
    input  logic      clock,
    input  logic      reset,

    // load/store queue side
    input  logic      lsq_req,
    input  lsq_req_t  lsq_req_data,
    output logic      lsq_ack,
    output lsq_rsp_t  lsq_rsp,

    // memory side
    input  mem_rsp_t  mem_rsp,
    output mem_req_t  mem_req,
    output logic      drained
);

    // stage one to stage two
    logic       miss_push;
    miss_rec_t  miss_rec;
    logic       queue_ready;

    // fill return into stage one
    fill_t      fill;

    dcache_lookup lookup_inst (
        .clock        (clock),
        .reset        (reset),
        .lsq_req      (lsq_req),
        .lsq_req_data (lsq_req_data),
        .fill         (fill),
        .queue_ready  (queue_ready),
        .lsq_ack      (lsq_ack),
        .lsq_rsp      (lsq_rsp),
        .miss_push    (miss_push),
        .miss_rec     (miss_rec)
    );

    dcache_miss_queue miss_queue_inst (
        .clock       (clock),
        .reset       (reset),
        .miss_push   (miss_push),
        .miss_rec    (miss_rec),
        .mem_rsp     (mem_rsp),
        .queue_ready (queue_ready),
        .fill        (fill),
        .mem_req     (mem_req),
        .drained     (drained)
    );

endmodule

//--- source/mem_bus_pkg.sv
/*
 * memory-side types
 *   bus command enum
 *   tagged memory request and response
 */

`include "dcache_params.svh"

package mem_bus_pkg;

    typedef enum logic [1:0] {
        BUS_NONE  = 2'd0,
        BUS_LOAD  = 2'd1,
        BUS_STORE = 2'd2
    } bus_cmd_e;

    // address is line aligned, be selects bytes for stores
    typedef struct packed {
        bus_cmd_e                  cmd;
        logic [`DC_ADDR_BITS-1:0]  addr;
        logic [63:0]               data;
        logic [7:0]                be;
    } mem_req_t;

    // accept_tag answers the offer in the same cycle
    // data_tag marks returning load data
    typedef struct packed {
        logic [`MEM_TAG_BITS-1:0]  accept_tag;
        logic [`MEM_TAG_BITS-1:0]  data_tag;
        logic [63:0]               data;
    } mem_rsp_t;

endpackage

//--- verif/dcache_props.sv
/*
 * concurrent assertions bound into the data cache
 *   lsq req/ack handshake
 *   memory command and fill pulse
 */

`timescale 1ns/1ps

module dcache_props
    import mem_bus_pkg::*;
(
    input logic        clock,
    input logic        reset,
    input logic        lsq_req,
    input logic        lsq_ack,
    input logic        fill_valid,
    input logic [1:0]  mem_cmd,
    input logic        queue_empty
);

    // failure count, watched from the testbench
    int error_count = 0;

    // ack is set on the edge that saw req, so req is checked one sample back
    ack_needs_req: assert property (@(posedge clock) disable iff (reset)
        $rose(lsq_ack) |-> $past(lsq_req))
    else begin
        $error("ack rose without a pending request");
        error_count++;
    end

    ack_holds: assert property (@(posedge clock) disable iff (reset)
        lsq_ack && lsq_req |=> lsq_ack)
    else begin
        $error("ack dropped while request still high");
        error_count++;
    end

    // nothing to offer from an empty queue
    idle_bus: assert property (@(posedge clock) disable iff (reset)
        queue_empty |-> mem_cmd == BUS_NONE)
    else begin
        $error("memory command active with an empty queue");
        error_count++;
    end

    fill_single_cycle: assert property (@(posedge clock) disable iff (reset)
        fill_valid |=> !fill_valid)
    else begin
        $error("fill pulse longer than one cycle");
        error_count++;
    end

endmodule

//--- verif/dcache_stim.txt
# op: 0 load, 1 store, 2 drain then check memory, 3 set refusal level (value = 0..7 of 8)
# op size(0 byte 1 half 2 word) addr(hex) value(hex) expected(hex) mem_reads(dec)
0 2 1000 00000000 b6b7b4b5 1
0 0 1005 00000000 000000b0 1
0 1 1006 00000000 0000b2b3 1
1 2 1004 deadbeef 00000000 1
0 2 1004 00000000 deadbeef 1
1 0 1001 00000077 00000000 1
0 2 1000 00000000 b6b777b5 1
2 2 1004 00000000 deadbeef 1
2 2 1000 00000000 b6b777b5 1
1 1 2002 0000cafe 00000000 1
2 1 2002 00000000 0000cafe 1
0 2 2000 00000000 cafe8485 2
0 1 2002 00000000 0000cafe 2
0 2 1000 00000000 b6b777b5 2
0 0 3000 00000000 00000095 3
0 0 3008 00000000 0000009d 4
0 0 3010 00000000 00000085 5
0 0 3018 00000000 0000008d 6
0 0 3020 00000000 000000b5 7
0 0 3028 00000000 000000bd 8
0 0 3030 00000000 000000a5 9
0 2 1000 00000000 b6b777b5 9
0 0 3008 00000000 0000009d 9
0 2 2000 00000000 cafe8485 10
0 0 3000 00000000 00000095 11
0 0 3018 00000000 0000008d 11
0 0 3010 00000000 00000085 12
0 0 3028 00000000 000000bd 12
0 0 3020 00000000 000000b5 13
0 0 3030 00000000 000000a5 14
0 1 1000 00000000 000077b5 15
3 0 0000 00000007 00000000 0
1 2 4000 11223344 00000000 15
1 2 4004 55667788 00000000 15
1 0 4008 00000099 00000000 15
1 1 400a 0000aabb 00000000 15
1 2 3000 01020304 00000000 15
1 0 400c 0000005a 00000000 15
2 2 4000 00000000 11223344 15
2 2 4004 00000000 55667788 15
2 2 4008 00000000 aabbec99 15
2 2 400c 00000000 eaebe85a 15
2 2 3004 00000000 92939091 15
2 2 3000 00000000 01020304 15
3 0 0000 00000005 00000000 0
0 2 3000 00000000 01020304 15
0 2 4000 00000000 11223344 16
0 1 400a 00000000 0000aabb 17
1 0 5000 00000042 00000000 17
0 0 5000 00000000 00000042 18
3 0 0000 00000000 00000000 0

//--- verif/dcache_tb.sv
/*
 * data cache testbench
 *   clock, reset and stim file driven lsq accesses
 *   tagged memory model with random refusals and return delays
 *   value checker, assertion binding and final report
 */

`timescale 1ns/1ps

`include "dcache_params.svh"

module dcache_tb
    import dcache_pkg::*;
    import mem_bus_pkg::*;
();

    localparam int    CLOCK_PERIOD = 40;
    localparam int    WAIT_LIMIT   = 4000;
    localparam string STIM_FILE    = "verif/dcache_stim.txt";

    logic      clock;
    logic      reset;
    logic      lsq_req;
    lsq_req_t  lsq_req_data;
    logic      lsq_ack;
    lsq_rsp_t  lsq_rsp;
    mem_rsp_t  mem_rsp;
    mem_req_t  mem_req;
    logic      drained;

    // memory model state
    logic [7:0]                mem [0:65535];
    integer                    seed = 8057;
    int                        refuse_level;
    int                        load_count;
    logic [`MEM_TAG_BITS-1:0]  next_tag;
    logic                      return_busy;
    int                        return_delay;
    logic [`MEM_TAG_BITS-1:0]  return_tag;
    logic [63:0]               return_data;

    dcache_top dcache_top_inst (
        .clock        (clock),
        .reset        (reset),
        .lsq_req      (lsq_req),
        .lsq_req_data (lsq_req_data),
        .lsq_ack      (lsq_ack),
        .lsq_rsp      (lsq_rsp),
        .mem_rsp      (mem_rsp),
        .mem_req      (mem_req),
        .drained      (drained)
    );

    // handshake side in lookup, bus side in the miss queue
    bind dcache_lookup dcache_props lookup_props (
        .clock       (clock),
        .reset       (reset),
        .lsq_req     (lsq_req),
        .lsq_ack     (lsq_ack),
        .fill_valid  (1'b0),
        .mem_cmd     (2'b00),
        .queue_empty (1'b1)
    );

    bind dcache_miss_queue dcache_props queue_props (
        .clock       (clock),
        .reset       (reset),
        .lsq_req     (1'b0),
        .lsq_ack     (1'b0),
        .fill_valid  (fill.valid),
        .mem_cmd     (mem_req.cmd),
        .queue_empty (!head.valid)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #(CLOCK_PERIOD / 2) clock = ~clock;
        end
    end

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////

    // initial memory content, every address bit matters
    function automatic logic [7:0] fill_byte(input logic [15:0] addr);
        fill_byte = addr[7:0] ^ addr[15:8] ^ 8'ha5;
    endfunction

    task automatic abort_run();
        $display("Test failed");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("mismatch %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            abort_run();
        end
    endtask

    // one four-phase access, checked at ack
    task automatic run_access(input int op, input int size, input logic [15:0] addr,
                              input logic [31:0] value, input logic [31:0] expected,
                              input int exp_reads);
        int cycles;
        @(negedge clock);
        lsq_req_data.op    = lsq_op_e'(op[0]);
        lsq_req_data.size  = access_size_e'(size[1:0]);
        lsq_req_data.addr  = addr;
        lsq_req_data.value = value;
        lsq_req            = 1'b1;
        cycles = 0;
        while (lsq_ack !== 1'b1) begin
            if (cycles == WAIT_LIMIT) begin
                $display("timeout waiting for ack at address 0x%0h", addr);
                abort_run();
            end
            @(negedge clock);
            cycles++;
        end
        if (op == 0) begin
            check_value("lsq_rsp.value", lsq_rsp.value, expected);
        end else begin
            // the write-through is still queued at ack
            check_value("drained", drained, 1'b0);
        end
        check_value("mem_load_count", load_count, exp_reads);
        // stores keep req up one more cycle so ack must hold
        if (op == 1) begin
            @(negedge clock);
        end
        lsq_req = 1'b0;
        cycles = 0;
        while (lsq_ack !== 1'b0) begin
            if (cycles == WAIT_LIMIT) begin
                $display("timeout waiting for ack release at address 0x%0h", addr);
                abort_run();
            end
            @(negedge clock);
            cycles++;
        end
    endtask

    task automatic check_memory(input int size, input logic [15:0] addr,
                                input logic [31:0] expected, input int exp_reads);
        int          cycles;
        logic [31:0] stored;
        @(negedge clock);
        cycles = 0;
        while (drained !== 1'b1) begin
            if (cycles == WAIT_LIMIT) begin
                $display("timeout waiting for the write-throughs to drain");
                abort_run();
            end
            @(negedge clock);
            cycles++;
        end
        stored = {mem[addr + 16'd3], mem[addr + 16'd2], mem[addr + 16'd1], mem[addr]};
        if (size == 0) begin
            stored = stored & 32'h0000_00ff;
        end else if (size == 1) begin
            stored = stored & 32'h0000_ffff;
        end
        check_value("memory", stored, expected);
        check_value("mem_load_count", load_count, exp_reads);
    endtask

    //////////////////////////////////////////////////
    // tagged memory model
    //////////////////////////////////////////////////

    always @(negedge clock) begin
        if (reset) begin
            mem_rsp     = '0;
            return_busy = 1'b0;
        end else begin
            // load data comes back as a one-cycle tagged pulse
            mem_rsp.data_tag = '0;
            if (return_busy) begin
                if (return_delay == 1) begin
                    mem_rsp.data_tag = return_tag;
                    mem_rsp.data     = return_data;
                    return_busy      = 1'b0;
                end else begin
                    return_delay--;
                end
            end

            mem_rsp.accept_tag = '0;
            if (mem_req.cmd == BUS_LOAD || mem_req.cmd == BUS_STORE) begin
                if (($random(seed) & 7) >= refuse_level) begin
                    mem_rsp.accept_tag = next_tag;
                    if (mem_req.cmd == BUS_STORE) begin
                        for (int b = 0; b < 8; b++) begin
                            if (mem_req.be[b]) begin
                                mem[mem_req.addr + 16'(b)] = mem_req.data[b*8 +: 8];
                            end
                        end
                    end else begin
                        load_count++;
                        for (int b = 0; b < 8; b++) begin
                            return_data[b*8 +: 8] = mem[mem_req.addr + 16'(b)];
                        end
                        return_tag   = next_tag;
                        return_busy  = 1'b1;
                        return_delay = 1 + ($unsigned($random(seed)) % 6);
                    end
                    // rotate through nonzero tags
                    if (next_tag == '1) begin
                        next_tag = 1;
                    end else begin
                        next_tag = next_tag + 1'b1;
                    end
                end
            end
        end
    end

    // first assertion failure ends the run
    always @(negedge clock) begin
        if (dcache_top_inst.lookup_inst.lookup_props.error_count != 0 ||
            dcache_top_inst.miss_queue_inst.queue_props.error_count != 0) begin
            $display("assertion failure reported inside the DUT");
            abort_run();
        end
    end

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////

    initial begin
        int          fd;
        int          status;
        int          fields;
        int          line_no;
        int          op;
        int          size;
        int          exp_reads;
        logic [31:0] addr;
        logic [31:0] value;
        logic [31:0] expected;
        string       line;

        reset        = 1'b1;
        lsq_req      = 1'b0;
        lsq_req_data = '0;
        mem_rsp      = '0;
        refuse_level = 0;
        load_count   = 0;
        next_tag     = 1;
        return_busy  = 1'b0;
        return_delay = 0;
        return_tag   = '0;
        return_data  = '0;
        for (int a = 0; a < 65536; a++) begin
            mem[a] = fill_byte(16'(a));
        end

        repeat (10) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        // state right after reset
        check_value("lsq_ack", lsq_ack, 1'b0);
        check_value("drained", drained, 1'b1);
        check_value("mem_req.cmd", mem_req.cmd, BUS_NONE);

        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("cannot open stimulus file %s", STIM_FILE);
            abort_run();
        end
        line_no = 0;
        while (!$feof(fd)) begin
            line   = "";
            status = $fgets(line, fd);
            line_no++;
            if (status != 0 && line.len() > 1 && line.getc(0) != "#") begin
                fields = $sscanf(line, "%d %d %h %h %h %d",
                                 op, size, addr, value, expected, exp_reads);
                if (fields != 6) begin
                    $display("stimulus line %0d is malformed", line_no);
                    abort_run();
                end
                case (op)
                    0, 1: run_access(op, size, addr[15:0], value, expected, exp_reads);
                    2: check_memory(size, addr[15:0], expected, exp_reads);
                    3: refuse_level = value;
                    default: begin
                        $display("unknown opcode %0d on stimulus line %0d", op, line_no);
                        abort_run();
                    end
                endcase
            end
        end
        $fclose(fd);

        repeat (2) @(negedge clock);
        if (dcache_top_inst.lookup_inst.lookup_props.error_count != 0 ||
            dcache_top_inst.miss_queue_inst.queue_props.error_count != 0) begin
            $display("assertion failure reported inside the DUT");
            abort_run();
        end else begin
            $display("Test completed successfully");
            $finish;
        end
    end

endmodule
